/* list.f */
+incdir+testbench
src/uart_cfg_pkg.sv
src/cfg_bus_decoder.sv
src/line_ctrl_regs.sv
src/divisor_reg.sv
src/fifo_port_regs.sv
src/uart_cfg_regs.sv
testbench/tb_uart_cfg_regs.sv

/* run.sh */
#!/bin/sh
# Build and run the register file testbench with Verilator
set -e

cd "$(dirname "$0")"
rm -rf obj_dir sim.log

verilator --binary --timing -f list.f --top-module tb_uart_cfg_regs -o sim_uart_cfg
./obj_dir/sim_uart_cfg > sim.log 2>&1
cat sim.log

if grep -q "TB FAILED" sim.log; then
    echo "simulation reported errors"
    exit 1
fi

if ! grep -q "TB PASSED" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi

exit 0

/* src/cfg_bus_decoder.sv */
/*
 * Register bus decoder
 * Write strobes, RXR read strobe and the read-data multiplexer
 */
`timescale 1ns/1ns

module cfg_bus_decoder import uart_cfg_pkg::*; (
    input  logic      read_i,
    input  logic      write_i,
    input  cfg_addr_t address_i,
    input  byte_t     str_i,
    input  byte_t     ctr_i,
    input  byte_t     isr_i,
    input  byte_t     dvr_lo_i,
    input  byte_t     dvr_hi_i,
    input  byte_t     fsr_i,
    input  byte_t     rxr_i,
    input  byte_t     txr_i,
    output reg_wr_t   wr_en_o,
    output logic      rxr_read_o,
    output byte_t     data_o
);

    // Write wins when both strobes are high
    always_comb begin
        wr_en_o    = '0;
        rxr_read_o = 1'b0;
        data_o     = '0;

        if (write_i) begin
            wr_en_o[address_i] = 1'b1;
        end else if (read_i) begin
            rxr_read_o = (address_i == RXR_ADDR);

            case (address_i)
                STR_ADDR:  data_o = str_i;
                LDVR_ADDR: data_o = dvr_lo_i;
                UDVR_ADDR: data_o = dvr_hi_i;
                FSR_ADDR:  data_o = fsr_i;
                CTR_ADDR:  data_o = ctr_i;
                ISR_ADDR:  data_o = isr_i;
                RXR_ADDR:  data_o = rxr_i;
                TXR_ADDR:  data_o = txr_i;
                default:   data_o = '0;
            endcase
        end
    end

endmodule : cfg_bus_decoder

/* src/divisor_reg.sv */
/*
 * Baud divisor register
 * Byte-wide writes, committed to the baud generator as one 16-bit value
 */
`timescale 1ns/1ns

module divisor_reg import uart_cfg_pkg::*; #(
    parameter divisor_t RESET_DIVISOR = 16'd325
) (
    input  logic      clk_i,
    input  logic      rst_n_i,
    input  reg_wr_t   wr_en_i,
    input  byte_t     data_i,
    input  cfg_addr_t address_i,
    input  logic      std_restore_i,
    input  logic      tx_idle_i,
    input  logic      rx_idle_i,
    output byte_t     dvr_lo_o,
    output byte_t     dvr_hi_o,
    output divisor_t  divisor_o,
    output logic      reset_bd_gen_o
);

    byte_t     dvr_lo_q;
    byte_t     dvr_hi_q;
    divisor_t  committed_q;
    cfg_addr_t addr_old_q;
    cfg_addr_t addr_last_q;
    logic      dvr_done;
    logic      both_idle;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            dvr_lo_q <= RESET_DIVISOR[7:0];
            dvr_hi_q <= RESET_DIVISOR[15:8];
        end else if (std_restore_i) begin
            dvr_lo_q <= RESET_DIVISOR[7:0];
            dvr_hi_q <= RESET_DIVISOR[15:8];
        end else begin
            if (wr_en_i[LDVR_ADDR]) begin
                dvr_lo_q <= data_i;
            end
            if (wr_en_i[UDVR_ADDR]) begin
                dvr_hi_q <= data_i;
            end
        end
    end

    // Last two bus addresses with the older one in addr_old_q
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            addr_old_q  <= STR_ADDR;
            addr_last_q <= STR_ADDR;
        end else begin
            addr_old_q  <= addr_last_q;
            addr_last_q <= address_i;
        end
    end

    assign dvr_done  = (addr_old_q == LDVR_ADDR) && (addr_last_q == UDVR_ADDR);
    assign both_idle = tx_idle_i & rx_idle_i;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            committed_q <= RESET_DIVISOR;
        end else if (std_restore_i) begin
            committed_q <= RESET_DIVISOR;
        end else if (dvr_done) begin
            committed_q <= {dvr_hi_q, dvr_lo_q};
        end
    end

    assign reset_bd_gen_o = dvr_done & both_idle;
    assign divisor_o      = both_idle ? committed_q : {dvr_hi_q, dvr_lo_q};

    assign dvr_lo_o = dvr_lo_q;
    assign dvr_hi_o = dvr_hi_q;

endmodule : divisor_reg

/* src/fifo_port_regs.sv */
/*
 * FIFO-facing registers
 * FSR threshold and status, RXR prefetch and pop, TXR with write pulse
 */
`timescale 1ns/1ns

module fifo_port_regs import uart_cfg_pkg::*; (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  reg_wr_t                wr_en_i,
    input  byte_t                  data_i,
    input  logic                   rxr_read_i,
    input  logic                   tx_fifo_full_i,
    input  logic                   rx_fifo_empty_i,
    input  byte_t                  rx_data_i,
    output byte_t                  fsr_o,
    output byte_t                  rxr_o,
    output byte_t                  txr_o,
    output logic [threshold_w-1:0] rx_fifo_threshold_o,
    output logic                   rx_fifo_read_o,
    output byte_t                  tx_data_o,
    output logic                   tx_fifo_write_o
);

    logic [threshold_w-1:0] threshold_q;
    logic                   tx_full_q;
    logic                   rx_empty_q;
    logic                   rx_empty_prev_q;
    logic                   rx_empty_fall;
    byte_t                  rxr_q;
    byte_t                  txr_q;
    logic                   tx_write_q;

    // ------------------------------
    // FSR
    // ------------------------------
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            threshold_q <= '0;
            tx_full_q   <= 1'b0;
            rx_empty_q  <= 1'b1;
        end else begin
            tx_full_q  <= tx_fifo_full_i;
            rx_empty_q <= rx_fifo_empty_i;
            if (wr_en_i[FSR_ADDR]) begin
                threshold_q <= data_i[threshold_w-1:0];
            end
        end
    end

    always_comb begin
        fsr_o                    = '0;
        fsr_o[threshold_w-1:0]   = threshold_q;
        fsr_o[fsr_tx_full_bit]   = tx_full_q;
        fsr_o[fsr_rx_empty_bit]  = rx_empty_q;
    end

    assign rx_fifo_threshold_o = threshold_q;

    // ------------------------------
    // RXR
    // ------------------------------
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rx_empty_prev_q <= 1'b1;
        end else begin
            rx_empty_prev_q <= rx_fifo_empty_i;
        end
    end

    // First word is fetched as soon as the FIFO leaves empty
    assign rx_empty_fall  = rx_empty_prev_q & ~rx_fifo_empty_i;
    assign rx_fifo_read_o = rx_empty_fall | (rxr_read_i & ~rx_fifo_empty_i);

    always_ff @(posedge clk_i) begin
        if (rx_fifo_read_o) begin
            rxr_q <= rx_data_i;
        end
    end

    assign rxr_o = rxr_q;

    // ------------------------------
    // TXR
    // ------------------------------
    always_ff @(posedge clk_i) begin
        if (wr_en_i[TXR_ADDR]) begin
            txr_q <= data_i;
        end
    end

    // Pulse lines up with the registered byte
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            tx_write_q <= 1'b0;
        end else begin
            tx_write_q <= wr_en_i[TXR_ADDR];
        end
    end

    assign txr_o           = txr_q;
    assign tx_data_o       = txr_q;
    assign tx_fifo_write_o = tx_write_q;

endmodule : fifo_port_regs

/* src/line_ctrl_regs.sv */
/*
 * Line settings, control and interrupt-enable registers
 * Holds STR, CTR and ISR and generates the standard-configuration restore
 */
`timescale 1ns/1ns

module line_ctrl_regs import uart_cfg_pkg::*; (
    input  logic         clk_i,
    input  logic         rst_n_i,
    input  reg_wr_t      wr_en_i,
    input  byte_t        data_i,
    input  logic         set_std_config_i,
    output logic         std_restore_o,
    output byte_t        str_o,
    output byte_t        ctr_o,
    output byte_t        isr_o,
    output logic         tx_dsm_o,
    output logic         rx_dsm_o,
    output data_width_t  data_width_o,
    output parity_mode_t parity_mode_o,
    output stop_bits_t   stop_bits_o,
    output logic         tx_enable_o,
    output logic         rx_enable_o,
    output logic         tx_done_en_o,
    output logic         rx_rdy_en_o,
    output logic         frame_error_en_o,
    output logic         parity_error_en_o,
    output logic         overrun_error_en_o
);

    byte_t      str_q;
    logic [1:0] comm_q;
    logic       std_config_q;
    logic [4:0] int_en_q;

    assign std_restore_o = std_config_q | set_std_config_i;

    // ------------------------------
    // STR and CTR enables
    // ------------------------------
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            str_q  <= str_reset;
            comm_q <= std_comm_mode;
        end else if (std_restore_o) begin
            str_q  <= str_reset;
            comm_q <= std_comm_mode;
        end else begin
            if (wr_en_i[STR_ADDR]) begin
                str_q <= data_i;
            end
            if (wr_en_i[CTR_ADDR]) begin
                comm_q <= {data_i[ctr_rx_en_bit], data_i[ctr_tx_en_bit]};
            end
        end
    end

    // Self-clearing bit that is high for a single cycle after the CTR write
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            std_config_q <= 1'b0;
        end else if (std_config_q) begin
            std_config_q <= 1'b0;
        end else if (wr_en_i[CTR_ADDR]) begin
            std_config_q <= data_i[ctr_std_cfg_bit];
        end
    end

    // ------------------------------
    // ISR enables
    // ------------------------------
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            int_en_q <= '1;
        end else if (wr_en_i[ISR_ADDR]) begin
            int_en_q <= {data_i[isr_tx_done_bit], data_i[isr_rx_rdy_bit],
                         data_i[isr_frame_bit], data_i[isr_parity_bit],
                         data_i[isr_overrun_bit]};
        end
    end

    // Field decode
    assign tx_dsm_o      = str_q[str_tx_dsm_bit];
    assign rx_dsm_o      = str_q[str_rx_dsm_bit];
    assign data_width_o  = data_width_t'(str_q[str_dw_lsb +: 2]);
    assign parity_mode_o = parity_mode_t'(str_q[str_par_lsb +: 2]);
    assign stop_bits_o   = stop_bits_t'(str_q[str_sb_lsb +: 2]);

    assign rx_enable_o = comm_q[1];
    assign tx_enable_o = comm_q[0];

    assign tx_done_en_o       = int_en_q[4];
    assign rx_rdy_en_o        = int_en_q[3];
    assign frame_error_en_o   = int_en_q[2];
    assign parity_error_en_o  = int_en_q[1];
    assign overrun_error_en_o = int_en_q[0];

    // Bus bytes with unused bits reading as zero
    always_comb begin
        str_o = str_q;

        ctr_o                  = '0;
        ctr_o[ctr_rx_en_bit]   = comm_q[1];
        ctr_o[ctr_tx_en_bit]   = comm_q[0];
        ctr_o[ctr_std_cfg_bit] = std_config_q;

        isr_o                  = '0;
        isr_o[isr_tx_done_bit] = int_en_q[4];
        isr_o[isr_rx_rdy_bit]  = int_en_q[3];
        isr_o[isr_frame_bit]   = int_en_q[2];
        isr_o[isr_parity_bit]  = int_en_q[1];
        isr_o[isr_overrun_bit] = int_en_q[0];
    end

endmodule : line_ctrl_regs

/* src/uart_cfg_pkg.sv */
/*
 * UART configuration register package
 * Register addresses, field layouts, line-setting encodings and reset defaults
 */
package uart_cfg_pkg;

    // ------------------------------
    // Basic bus types
    // ------------------------------
    typedef logic [7:0]  byte_t;
    typedef logic [15:0] divisor_t;

    // One strobe per register address
    typedef logic [7:0]  reg_wr_t;

    typedef enum logic [2:0] {
        STR_ADDR  = 3'd0,
        LDVR_ADDR = 3'd1,
        UDVR_ADDR = 3'd2,
        FSR_ADDR  = 3'd3,
        CTR_ADDR  = 3'd4,
        ISR_ADDR  = 3'd5,
        RXR_ADDR  = 3'd6,
        TXR_ADDR  = 3'd7
    } cfg_addr_t;

    // ------------------------------
    // Line setting encodings
    // ------------------------------
    typedef enum logic [1:0] {DW_5, DW_6, DW_7, DW_8} data_width_t;
    typedef enum logic [1:0] {PAR_EVEN, PAR_ODD, PAR_NONE, PAR_NONE2} parity_mode_t;
    typedef enum logic [1:0] {SB_1, SB_2, SB_RSVD0, SB_RSVD1} stop_bits_t;

    localparam data_width_t  std_data_width  = DW_8;
    localparam parity_mode_t std_parity_mode = PAR_NONE;
    localparam stop_bits_t   std_stop_bits   = SB_1;

    // Bit 1 is rx enable, bit 0 is tx enable
    localparam logic [1:0] std_comm_mode = 2'b11;

    localparam int threshold_w = 6;

    // ------------------------------
    // Register field layouts
    // ------------------------------
    localparam int str_tx_dsm_bit  = 7;
    localparam int str_rx_dsm_bit  = 6;
    localparam int str_dw_lsb      = 4;
    localparam int str_par_lsb     = 2;
    localparam int str_sb_lsb      = 0;
    localparam byte_t str_reset = {2'b00, std_data_width, std_parity_mode, std_stop_bits};

    localparam int ctr_rx_en_bit   = 4;
    localparam int ctr_tx_en_bit   = 3;
    localparam int ctr_std_cfg_bit = 0;

    localparam int isr_tx_done_bit = 7;
    localparam int isr_rx_rdy_bit  = 6;
    localparam int isr_frame_bit   = 5;
    localparam int isr_parity_bit  = 4;
    localparam int isr_overrun_bit = 3;

    localparam int fsr_tx_full_bit  = 7;
    localparam int fsr_rx_empty_bit = 6;

endpackage : uart_cfg_pkg

/* src/uart_cfg_regs.sv */
/*
 * UART configuration register file
 * CPU register bus, line settings, baud divisor and FIFO-facing registers
 */
`timescale 1ns/1ns

module uart_cfg_regs import uart_cfg_pkg::*; #(
    parameter divisor_t RESET_DIVISOR = 16'd325
) (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic                   read_i,
    input  logic                   write_i,
    input  cfg_addr_t              address_i,
    input  byte_t                  data_i,
    input  logic                   set_std_config_i,
    input  logic                   tx_idle_i,
    input  logic                   rx_idle_i,
    input  logic                   tx_fifo_full_i,
    input  logic                   rx_fifo_empty_i,
    input  byte_t                  rx_data_i,
    output byte_t                  data_o,
    output logic                   tx_dsm_o,
    output logic                   rx_dsm_o,
    output data_width_t            data_width_o,
    output parity_mode_t           parity_mode_o,
    output stop_bits_t             stop_bits_o,
    output divisor_t               divisor_o,
    output logic                   reset_bd_gen_o,
    output logic [threshold_w-1:0] rx_fifo_threshold_o,
    output logic                   tx_enable_o,
    output logic                   rx_enable_o,
    output logic                   tx_done_en_o,
    output logic                   rx_rdy_en_o,
    output logic                   frame_error_en_o,
    output logic                   parity_error_en_o,
    output logic                   overrun_error_en_o,
    output logic                   rx_fifo_read_o,
    output byte_t                  tx_data_o,
    output logic                   tx_fifo_write_o
);

    reg_wr_t wr_en;
    logic    rxr_read;
    logic    std_restore;

    // Register bytes returned to the read mux
    byte_t   str;
    byte_t   ctr;
    byte_t   isr;
    byte_t   dvr_lo;
    byte_t   dvr_hi;
    byte_t   fsr;
    byte_t   rxr;
    byte_t   txr;

    cfg_bus_decoder u_cfg_bus_decoder (
        .read_i     (read_i),
        .write_i    (write_i),
        .address_i  (address_i),
        .str_i      (str),
        .ctr_i      (ctr),
        .isr_i      (isr),
        .dvr_lo_i   (dvr_lo),
        .dvr_hi_i   (dvr_hi),
        .fsr_i      (fsr),
        .rxr_i      (rxr),
        .txr_i      (txr),
        .wr_en_o    (wr_en),
        .rxr_read_o (rxr_read),
        .data_o     (data_o)
    );

    line_ctrl_regs u_line_ctrl_regs (
        .clk_i              (clk_i),
        .rst_n_i            (rst_n_i),
        .wr_en_i            (wr_en),
        .data_i             (data_i),
        .set_std_config_i   (set_std_config_i),
        .std_restore_o      (std_restore),
        .str_o              (str),
        .ctr_o              (ctr),
        .isr_o              (isr),
        .tx_dsm_o           (tx_dsm_o),
        .rx_dsm_o           (rx_dsm_o),
        .data_width_o       (data_width_o),
        .parity_mode_o      (parity_mode_o),
        .stop_bits_o        (stop_bits_o),
        .tx_enable_o        (tx_enable_o),
        .rx_enable_o        (rx_enable_o),
        .tx_done_en_o       (tx_done_en_o),
        .rx_rdy_en_o        (rx_rdy_en_o),
        .frame_error_en_o   (frame_error_en_o),
        .parity_error_en_o  (parity_error_en_o),
        .overrun_error_en_o (overrun_error_en_o)
    );

    divisor_reg #(
        .RESET_DIVISOR (RESET_DIVISOR)
    ) u_divisor_reg (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .wr_en_i        (wr_en),
        .data_i         (data_i),
        .address_i      (address_i),
        .std_restore_i  (std_restore),
        .tx_idle_i      (tx_idle_i),
        .rx_idle_i      (rx_idle_i),
        .dvr_lo_o       (dvr_lo),
        .dvr_hi_o       (dvr_hi),
        .divisor_o      (divisor_o),
        .reset_bd_gen_o (reset_bd_gen_o)
    );

    fifo_port_regs u_fifo_port_regs (
        .clk_i               (clk_i),
        .rst_n_i             (rst_n_i),
        .wr_en_i             (wr_en),
        .data_i              (data_i),
        .rxr_read_i          (rxr_read),
        .tx_fifo_full_i      (tx_fifo_full_i),
        .rx_fifo_empty_i     (rx_fifo_empty_i),
        .rx_data_i           (rx_data_i),
        .fsr_o               (fsr),
        .rxr_o               (rxr),
        .txr_o               (txr),
        .rx_fifo_threshold_o (rx_fifo_threshold_o),
        .rx_fifo_read_o      (rx_fifo_read_o),
        .tx_data_o           (tx_data_o),
        .tx_fifo_write_o     (tx_fifo_write_o)
    );

endmodule : uart_cfg_regs

/* testbench/tb_vectors.svh */
/*
 * Register test table for the UART configuration register file
 * Each step holds an operation, a selector, data and the expected value
 */
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// Operations
localparam int OP_WRITE   = 0;
localparam int OP_READ    = 1;
localparam int OP_STD     = 2;
localparam int OP_IDLE    = 3;
localparam int OP_PUSH    = 4;
localparam int OP_RELEASE = 5;
localparam int OP_CHECK   = 6;
localparam int OP_WAIT    = 7;
localparam int OP_MARK    = 8;
localparam int OP_FULL    = 9;

// Output groups for OP_CHECK
localparam int CHK_LINE    = 0;
localparam int CHK_EN      = 1;
localparam int CHK_IRQ     = 2;
localparam int CHK_THR     = 3;
localparam int CHK_DIV     = 4;
localparam int CHK_TXW     = 5;
localparam int CHK_STROBES = 6;
localparam int CHK_BDCNT   = 7;
localparam int CHK_TXCNT   = 8;
localparam int CHK_POPS    = 9;

// Events for OP_WAIT
localparam int WAIT_BD = 0;
localparam int WAIT_RX = 1;

typedef struct {
    int          op;
    int          test;
    int          sel;
    logic [15:0] data;
    logic [15:0] exp_val;
} step_t;

step_t steps[$];
int    load_test;

string test_name [6] = '{"reset values", "write and readback", "divisor commit",
                         "standard configuration", "receive path", "transmit path"};

task automatic add_step(int op, int sel, logic [15:0] data, logic [15:0] exp_val);
    step_t s;
    s.op      = op;
    s.test    = load_test;
    s.sel     = sel;
    s.data    = data;
    s.exp_val = exp_val;
    steps.push_back(s);
endtask

// Changes STR, CTR and DVR away from their defaults
task automatic add_dirty_config();
    add_step(OP_WRITE, int'(STR_ADDR), 16'h00C5, 16'h0000);
    add_step(OP_WRITE, int'(CTR_ADDR), 16'h0008, 16'h0000);
    add_step(OP_WRITE, int'(LDVR_ADDR), 16'h0011, 16'h0000);
    add_step(OP_WRITE, int'(UDVR_ADDR), 16'h0022, 16'h0000);
endtask

// STR default is 8-bit words with no parity and one stop bit
task automatic add_default_reads();
    add_step(OP_READ, int'(STR_ADDR), 16'h0000, 16'h0038);
    add_step(OP_READ, int'(CTR_ADDR), 16'h0000, 16'h0018);
    add_step(OP_READ, int'(LDVR_ADDR), 16'h0000, {8'h00, RESET_DIVISOR[7:0]});
    add_step(OP_READ, int'(UDVR_ADDR), 16'h0000, {8'h00, RESET_DIVISOR[15:8]});
    add_step(OP_CHECK, CHK_LINE, 16'h0000, 16'h0038);
    add_step(OP_CHECK, CHK_EN, 16'h0000, 16'h0018);
    add_step(OP_CHECK, CHK_DIV, 16'h0000, RESET_DIVISOR);
endtask

task automatic load_vectors();
    byte_t r;
    byte_t c;
    byte_t i;
    byte_t thr;
    byte_t t;
    byte_t w [3];

    load_test = 0;
    add_step(OP_CHECK, CHK_STROBES, 16'h0000, 16'h0000);
    add_step(OP_READ, int'(ISR_ADDR), 16'h0000, 16'h00F8);
    add_step(OP_READ, int'(FSR_ADDR), 16'h0000, 16'h0040);
    add_step(OP_CHECK, CHK_IRQ, 16'h0000, 16'h00F8);
    add_step(OP_CHECK, CHK_THR, 16'h0000, 16'h0000);
    add_default_reads();

    load_test = 1;
    r   = 8'($urandom());
    c   = 8'($urandom()) & 8'hFE;
    i   = 8'($urandom());
    thr = 8'($urandom());
    add_step(OP_WRITE, int'(STR_ADDR), {8'h00, r}, 16'h0000);
    add_step(OP_CHECK, CHK_LINE, 16'h0000, {8'h00, r});
    add_step(OP_READ, int'(STR_ADDR), 16'h0000, {8'h00, r});
    add_step(OP_WRITE, int'(CTR_ADDR), {8'h00, c}, 16'h0000);
    add_step(OP_CHECK, CHK_EN, 16'h0000, {8'h00, c & 8'h18});
    add_step(OP_READ, int'(CTR_ADDR), 16'h0000, {8'h00, c & 8'h18});
    add_step(OP_WRITE, int'(ISR_ADDR), {8'h00, i}, 16'h0000);
    add_step(OP_CHECK, CHK_IRQ, 16'h0000, {8'h00, i & 8'hF8});
    add_step(OP_READ, int'(ISR_ADDR), 16'h0000, {8'h00, i & 8'hF8});
    add_step(OP_WRITE, int'(FSR_ADDR), {8'h00, thr}, 16'h0000);
    add_step(OP_CHECK, CHK_THR, 16'h0000, {8'h00, thr & 8'h3F});
    add_step(OP_READ, int'(FSR_ADDR), 16'h0000, {8'h00, (thr & 8'h3F) | 8'h40});

    load_test = 2;
    add_step(OP_IDLE, 0, 16'h0003, 16'h0000);
    add_step(OP_MARK, 0, 16'h0000, 16'h0000);
    add_step(OP_WRITE, int'(LDVR_ADDR), 16'h0034, 16'h0000);
    add_step(OP_WRITE, int'(UDVR_ADDR), 16'h0012, 16'h0000);
    add_step(OP_WAIT, WAIT_BD, 16'h0000, 16'h0000);
    add_step(OP_CHECK, CHK_BDCNT, 16'h0000, 16'h0001);
    add_step(OP_CHECK, CHK_DIV, 16'h0000, 16'h1234);
    // With tx busy the divisor follows the live bytes
    add_step(OP_IDLE, 0, 16'h0001, 16'h0000);
    add_step(OP_WRITE, int'(LDVR_ADDR), 16'h0078, 16'h0000);
    add_step(OP_CHECK, CHK_DIV, 16'h0000, 16'h1278);
    add_step(OP_IDLE, 0, 16'h0003, 16'h0000);
    add_step(OP_CHECK, CHK_DIV, 16'h0000, 16'h1234);

    load_test = 3;
    add_dirty_config();
    add_step(OP_WRITE, int'(CTR_ADDR), 16'h0001, 16'h0000);
    add_step(OP_READ, int'(CTR_ADDR), 16'h0000, 16'h0001);
    add_default_reads();
    add_dirty_config();
    add_step(OP_STD, 0, 16'h0000, 16'h0000);
    add_default_reads();

    load_test = 4;
    w[0] = 8'($urandom());
    w[1] = 8'($urandom());
    w[2] = 8'($urandom());
    add_step(OP_MARK, 0, 16'h0000, 16'h0000);
    add_step(OP_PUSH, 0, {8'h00, w[0]}, 16'h0000);
    add_step(OP_PUSH, 0, {8'h00, w[1]}, 16'h0000);
    add_step(OP_PUSH, 0, {8'h00, w[2]}, 16'h0000);
    add_step(OP_RELEASE, 0, 16'h0000, 16'h0000);
    add_step(OP_WAIT, WAIT_RX, 16'h0000, 16'h0000);
    add_step(OP_READ, int'(RXR_ADDR), 16'h0000, {8'h00, w[0]});
    add_step(OP_READ, int'(RXR_ADDR), 16'h0000, {8'h00, w[1]});
    add_step(OP_READ, int'(RXR_ADDR), 16'h0000, {8'h00, w[2]});
    add_step(OP_CHECK, CHK_POPS, 16'h0000, 16'h0003);
    add_step(OP_READ, int'(FSR_ADDR), 16'h0000, {8'h00, (thr & 8'h3F) | 8'h40});

    load_test = 5;
    t = 8'($urandom());
    add_step(OP_MARK, 0, 16'h0000, 16'h0000);
    // TX FIFO reports full, the write still goes out
    add_step(OP_FULL, 0, 16'h0001, 16'h0000);
    add_step(OP_WRITE, int'(TXR_ADDR), {8'h00, t}, 16'h0000);
    add_step(OP_CHECK, CHK_TXW, 16'h0000, {8'h01, t});
    add_step(OP_READ, int'(TXR_ADDR), 16'h0000, {8'h00, t});
    add_step(OP_READ, int'(FSR_ADDR), 16'h0000, {8'h00, (thr & 8'h3F) | 8'hC0});
    add_step(OP_CHECK, CHK_TXCNT, 16'h0000, 16'h0001);
endtask

`endif

/* testbench/tb_uart_cfg_regs.sv */
/*
 * Testbench for the UART configuration register file
 * Applies the register test table, models the RX FIFO and reports per test
 */
`timescale 1ns/1ns

module tb_uart_cfg_regs import uart_cfg_pkg::*; ;

    localparam divisor_t RESET_DIVISOR = 16'd325;
    localparam int       TIMEOUT       = 20;

    logic                   clk_i;
    logic                   rst_n_i;
    logic                   read_i;
    logic                   write_i;
    cfg_addr_t              address_i;
    byte_t                  data_i;
    logic                   set_std_config_i;
    logic                   tx_idle_i;
    logic                   rx_idle_i;
    logic                   tx_fifo_full_i;
    logic                   rx_fifo_empty_i;
    byte_t                  rx_data_i;
    byte_t                  data_o;
    logic                   tx_dsm_o;
    logic                   rx_dsm_o;
    data_width_t            data_width_o;
    parity_mode_t           parity_mode_o;
    stop_bits_t             stop_bits_o;
    divisor_t               divisor_o;
    logic                   reset_bd_gen_o;
    logic [threshold_w-1:0] rx_fifo_threshold_o;
    logic                   tx_enable_o;
    logic                   rx_enable_o;
    logic                   tx_done_en_o;
    logic                   rx_rdy_en_o;
    logic                   frame_error_en_o;
    logic                   parity_error_en_o;
    logic                   overrun_error_en_o;
    logic                   rx_fifo_read_o;
    byte_t                  tx_data_o;
    logic                   tx_fifo_write_o;

    `include "tb_vectors.svh"

    // RX FIFO model and event counters
    byte_t rx_q[$];
    logic  rx_hold;
    int    pops;
    int    bd_cnt;
    int    tx_cnt;
    int    pop_mark;
    int    bd_mark;
    int    tx_mark;
    int    errors;
    int    test_err;
    int    tests_failed;

    uart_cfg_regs #(
        .RESET_DIVISOR (RESET_DIVISOR)
    ) u_uart_cfg_regs (.*);

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    task automatic check_value(string what, logic [15:0] got, logic [15:0] exp_val);
        if (got !== exp_val) begin
            $display("FAIL %0t ns: %s is %h, expected %h", $time, what, got, exp_val);
            errors++;
            test_err++;
        end
    endtask

    task automatic drive_rx();
        if (rx_hold || rx_q.size() == 0) begin
            rx_fifo_empty_i = 1'b1;
            rx_data_i       = 8'h00;
        end else begin
            rx_fifo_empty_i = 1'b0;
            rx_data_i       = rx_q[0];
        end
    endtask

    // Counts what the coming rising edge will see and moves to the next falling edge
    task automatic next_cycle();
        if (rx_fifo_read_o && rx_q.size() > 0) begin
            void'(rx_q.pop_front());
            pops++;
        end
        if (reset_bd_gen_o) begin
            bd_cnt++;
        end
        if (tx_fifo_write_o) begin
            tx_cnt++;
        end
        @(negedge clk_i);
        drive_rx();
    endtask

    task automatic wait_event(int sel);
        int   n;
        logic pending;
        n = 0;
        pending = (sel == WAIT_BD) ? (bd_cnt == bd_mark) : (pops == pop_mark);
        while (pending && n < TIMEOUT) begin
            next_cycle();
            #1;
            n++;
            pending = (sel == WAIT_BD) ? (bd_cnt == bd_mark) : (pops == pop_mark);
        end
        if (pending) begin
            $display("Timeout after %0d cycles waiting for %s", TIMEOUT,
                     (sel == WAIT_BD) ? "the baud generator reset" : "the RX prefetch");
            errors++;
            test_err++;
        end
    endtask

    task automatic run_check(int sel, logic [15:0] exp_val);
        case (sel)
            CHK_LINE: check_value("line settings", {8'h00, tx_dsm_o, rx_dsm_o,
                data_width_o, parity_mode_o, stop_bits_o}, exp_val);
            CHK_EN: check_value("enables", {11'd0, rx_enable_o, tx_enable_o, 3'd0}, exp_val);
            CHK_IRQ: check_value("interrupt enables", {8'h00, tx_done_en_o, rx_rdy_en_o,
                frame_error_en_o, parity_error_en_o, overrun_error_en_o, 3'd0}, exp_val);
            CHK_THR: check_value("threshold", {10'd0, rx_fifo_threshold_o}, exp_val);
            CHK_DIV: check_value("divisor", divisor_o, exp_val);
            CHK_TXW: check_value("tx write and data", {7'd0, tx_fifo_write_o, tx_data_o},
                exp_val);
            CHK_STROBES: check_value("strobes", {13'd0, tx_fifo_write_o, rx_fifo_read_o,
                reset_bd_gen_o}, exp_val);
            CHK_BDCNT: check_value("baud reset pulses", 16'(bd_cnt - bd_mark), exp_val);
            CHK_TXCNT: check_value("tx write pulses", 16'(tx_cnt - tx_mark), exp_val);
            default: check_value("rx pops", 16'(pops - pop_mark), exp_val);
        endcase
    endtask

    task automatic report_test(int id);
        if (test_err != 0) begin
            tests_failed++;
        end
        $display("test %0d %s: %0d errors", id, test_name[id[2:0]], test_err);
        test_err = 0;
    endtask

    initial begin
        step_t s;
        int    cur;

        void'($urandom(32'h6013));
        rst_n_i          = 1'b0;
        read_i           = 1'b0;
        write_i          = 1'b0;
        address_i        = STR_ADDR;
        data_i           = 8'h00;
        set_std_config_i = 1'b0;
        tx_idle_i        = 1'b1;
        rx_idle_i        = 1'b1;
        tx_fifo_full_i   = 1'b0;
        rx_hold          = 1'b0;
        pops             = 0;
        bd_cnt           = 0;
        tx_cnt           = 0;
        pop_mark         = 0;
        bd_mark          = 0;
        tx_mark          = 0;
        errors           = 0;
        test_err         = 0;
        tests_failed     = 0;
        drive_rx();
        load_vectors();

        repeat (2) @(posedge clk_i);
        @(negedge clk_i);
        rst_n_i = 1'b1;
        cur = 0;

        foreach (steps[k]) begin
            s = steps[k];
            if (s.test != cur) begin
                report_test(cur);
                cur = s.test;
            end
            write_i = 1'b0;
            read_i = 1'b0;
            address_i = STR_ADDR;
            data_i = 8'h00;
            set_std_config_i = 1'b0;
            case (s.op)
                OP_WRITE: begin
                    write_i = 1'b1;
                    address_i = cfg_addr_t'(s.sel[2:0]);
                    data_i = s.data[7:0];
                end
                OP_READ: begin
                    read_i = 1'b1;
                    address_i = cfg_addr_t'(s.sel[2:0]);
                end
                OP_STD: set_std_config_i = 1'b1;
                OP_IDLE: begin
                    tx_idle_i = s.data[1];
                    rx_idle_i = s.data[0];
                end
                OP_PUSH: begin
                    rx_hold = 1'b1;
                    rx_q.push_back(s.data[7:0]);
                end
                OP_RELEASE: begin
                    rx_hold = 1'b0;
                    drive_rx();
                end
                OP_MARK: begin
                    bd_mark = bd_cnt;
                    tx_mark = tx_cnt;
                    pop_mark = pops;
                end
                OP_FULL: tx_fifo_full_i = s.data[0];
                default: ;
            endcase
            #1;
            if (s.op == OP_READ) begin
                check_value("read data", {8'h00, data_o}, s.exp_val);
            end
            if (s.op == OP_CHECK) begin
                run_check(s.sel, s.exp_val);
            end
            if (s.op == OP_WAIT) begin
                wait_event(s.sel);
            end
            next_cycle();
        end
        report_test(cur);

        $display("tests run %0d, tests failed %0d, errors %0d", cur + 1, tests_failed, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule : tb_uart_cfg_regs
